//--- flist.f
hdl/axi_arb_pkg.sv
hdl/rr_arbiter.sv
hdl/req_buffer.sv
hdl/ar_merge.sv
hdl/r_route.sv
hdl/axi_rd_arbiter.sv
tb/tb_axi_rd_arbiter.sv

//--- Makefile
# Verilator simulation of the AXI read arbiter testbench

TOP := tb_axi_rd_arbiter

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Done: errors found" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_axi_rd_arbiter.sv
// Testbench for the four-port AXI4 read arbiter
// Models the round-robin grant and the two-entry request buffer,
// runs directed and random traffic and checks both channels

`timescale 1ns/1ps

module tb_axi_rd_arbiter;

    localparam int NUM_PORTS   = 4;
    localparam int ID_WIDTH    = 4;
    localparam int ADDR_WIDTH  = 32;
    localparam int DATA_WIDTH  = 64;
    localparam int LEN_WIDTH   = axi_arb_pkg::AXI_LEN_WIDTH;
    localparam int RESP_WIDTH  = axi_arb_pkg::AXI_RESP_WIDTH;
    localparam int ENTRY_WIDTH = ID_WIDTH + LEN_WIDTH + ADDR_WIDTH;
    localparam int SEL_W       = $clog2(NUM_PORTS);
    // Eight bytes per 64-bit beat
    localparam int EXP_SIZE    = 3;
    localparam int CLK_PERIOD  = 4;
    localparam int RAND_CYCLES = 300;
    // Cycles needed by all tests together
    localparam int TEST_CYCLES = 5 + 4 * 6 + 12 + 16 + 10 + RAND_CYCLES + 8;

    logic                                  sys_clk;
    logic                                  reset;
    logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0]  s_araddr;
    logic [NUM_PORTS-1:0][LEN_WIDTH-1:0]   s_arlen;
    logic [NUM_PORTS-1:0]                  s_arvalid;
    logic [NUM_PORTS-1:0]                  s_arready;
    logic [NUM_PORTS-1:0][ID_WIDTH-1:0]    s_rid;
    logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]  s_rdata;
    logic [NUM_PORTS-1:0][RESP_WIDTH-1:0]  s_rresp;
    logic [NUM_PORTS-1:0]                  s_rlast;
    logic [NUM_PORTS-1:0]                  s_rvalid;
    logic [NUM_PORTS-1:0]                  s_rready;
    logic [ID_WIDTH-1:0]                   m_arid;
    logic [ADDR_WIDTH-1:0]                 m_araddr;
    logic [LEN_WIDTH-1:0]                  m_arlen;
    logic [axi_arb_pkg::AXI_SIZE_WIDTH-1:0]  m_arsize;
    logic [axi_arb_pkg::AXI_BURST_WIDTH-1:0] m_arburst;
    logic                                  m_arlock;
    logic [axi_arb_pkg::AXI_CACHE_WIDTH-1:0] m_arcache;
    logic [axi_arb_pkg::AXI_PROT_WIDTH-1:0]  m_arprot;
    logic                                  m_arvalid;
    logic                                  m_arready;
    logic [ID_WIDTH-1:0]                   m_rid;
    logic [DATA_WIDTH-1:0]                 m_rdata;
    logic [RESP_WIDTH-1:0]                 m_rresp;
    logic                                  m_rlast;
    logic                                  m_rvalid;
    logic                                  m_rready;

    logic [ENTRY_WIDTH-1:0] model_q[$];
    int                     model_ptr;
    string                  test_name;
    int                     error_count;
    int                     errors_at_start;
    int                     tests_run;
    int                     tests_failed;

    axi_rd_arbiter #(.DATA_WIDTH(DATA_WIDTH)) u_dut (.*);

    initial begin : clock_gen
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    //------------------------------
    // Reference model
    //------------------------------
    // First requester at or after the pointer, -1 when nobody asks
    function automatic int next_winner(logic [NUM_PORTS-1:0] req, int ptr);
        int idx;
        next_winner = -1;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            idx = (ptr + i) % NUM_PORTS;
            if (req[SEL_W'(idx)]) begin
                next_winner = idx;
            end
        end
    endfunction

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        assert (expected === actual) else begin
            $display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    always @(posedge sys_clk) begin : compare
        int                     win;
        logic [SEL_W-1:0]       win_sel;
        logic [NUM_PORTS-1:0]   exp_grant;
        logic [ENTRY_WIDTH-1:0] head;
        if (reset) begin
            model_q.delete();
            model_ptr = 0;
        end else begin
            check_value("m_arvalid", 64'(model_q.size() != 0), 64'(m_arvalid));
            win = (model_q.size() < 2) ? next_winner(s_arvalid, model_ptr) : -1;
            win_sel = SEL_W'(win);
            exp_grant = '0;
            if (win >= 0) begin
                exp_grant[win_sel] = 1'b1;
            end
            check_value("s_arready", 64'(exp_grant), 64'(s_arready));
            if (m_arvalid && m_arready && model_q.size() != 0) begin
                head = model_q.pop_front();
                check_value("m_arid", 64'(head[ENTRY_WIDTH-1 -: ID_WIDTH]), 64'(m_arid));
                check_value("m_arlen", 64'(head[ADDR_WIDTH +: LEN_WIDTH]), 64'(m_arlen));
                check_value("m_araddr", 64'(head[ADDR_WIDTH-1:0]), 64'(m_araddr));
            end
            if (win >= 0) begin
                model_q.push_back({ID_WIDTH'(win), s_arlen[win_sel], s_araddr[win_sel]});
                model_ptr = (win + 1) % NUM_PORTS;
            end
        end
    end

    //------------------------------
    // Helpers
    //------------------------------
    task automatic start_test(string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    task automatic drain_requests();
        @(negedge sys_clk);
        s_arvalid = '0;
        m_arready = 1'b1;
        @(posedge sys_clk);
        while (m_arvalid) begin
            @(posedge sys_clk);
        end
    endtask

    task automatic drive_beat(logic [ID_WIDTH-1:0] id, logic valid);
        m_rid    = id;
        m_rdata  = {$urandom(), $urandom()};
        m_rresp  = RESP_WIDTH'($urandom());
        m_rlast  = 1'b1;
        m_rvalid = valid;
        s_rready = NUM_PORTS'($urandom());
    endtask

    // Valid and ready follow the owner of rid, payload goes everywhere
    task automatic check_route();
        logic [NUM_PORTS-1:0] exp_valid;
        logic                 exp_ready;
        exp_valid = '0;
        exp_ready = 1'b0;
        if (int'(m_rid) < NUM_PORTS) begin
            exp_valid[m_rid[SEL_W-1:0]] = m_rvalid;
            exp_ready = s_rready[m_rid[SEL_W-1:0]];
        end
        check_value("s_rvalid", 64'(exp_valid), 64'(s_rvalid));
        check_value("m_rready", 64'(exp_ready), 64'(m_rready));
        for (int k = 0; k < NUM_PORTS; k++) begin
            check_value("s_rdata", m_rdata, s_rdata[SEL_W'(k)]);
            check_value("s_rid", 64'(m_rid), 64'(s_rid[SEL_W'(k)]));
            check_value("s_rresp", 64'(m_rresp), 64'(s_rresp[SEL_W'(k)]));
            check_value("s_rlast", 64'(m_rlast), 64'(s_rlast[SEL_W'(k)]));
        end
    endtask

    //------------------------------
    // Tests
    //------------------------------
    task automatic single_request_test();
        logic [ADDR_WIDTH-1:0] addr;
        start_test("single_request");
        for (int p = 0; p < NUM_PORTS; p++) begin
            addr = $urandom();
            @(negedge sys_clk);
            s_araddr[SEL_W'(p)] = addr;
            s_arlen[SEL_W'(p)]  = '0;
            s_arvalid = NUM_PORTS'(1) << p;
            m_arready = 1'b1;
            @(posedge sys_clk);
            while (!s_arready[SEL_W'(p)]) begin
                @(posedge sys_clk);
            end
            @(negedge sys_clk);
            s_arvalid = '0;
            // One cycle after the handshake
            check_value("m_arvalid", 64'(1), 64'(m_arvalid));
            check_value("m_arid", 64'(p), 64'(m_arid));
            check_value("m_araddr", 64'(addr), 64'(m_araddr));
            check_value("m_arlen", 64'(0), 64'(m_arlen));
            check_value("m_arsize", 64'(EXP_SIZE), 64'(m_arsize));
            check_value("m_arburst", 64'(axi_arb_pkg::BURST_INCR), 64'(m_arburst));
            check_value("m_arlock", 64'(0), 64'(m_arlock));
            check_value("m_arcache", 64'(0), 64'(m_arcache));
            check_value("m_arprot", 64'(0), 64'(m_arprot));
        end
        drain_requests();
        finish_test();
    endtask

    task automatic rotation_test();
        int expected_order[5];
        expected_order = '{0, 1, 2, 3, 0};
        start_test("rotation");
        @(negedge sys_clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            s_araddr[SEL_W'(p)] = ADDR_WIDTH'(32'h1000 * (p + 1));
        end
        s_arvalid = '1;
        m_arready = 1'b1;
        for (int n = 0; n < 5; n++) begin
            @(posedge sys_clk);
            check_value("winner", 64'(NUM_PORTS'(1) << expected_order[n]), 64'(s_arready));
        end
        drain_requests();
        finish_test();
    endtask

    task automatic back_pressure_test();
        int accepted;
        start_test("back_pressure");
        accepted = 0;
        @(negedge sys_clk);
        m_arready = 1'b0;
        s_arvalid = '1;
        for (int n = 0; n < 8; n++) begin
            @(posedge sys_clk);
            if (s_arready != '0) begin
                accepted++;
            end
        end
        check_value("accepted requests", 64'(2), 64'(accepted));
        drain_requests();
        finish_test();
    endtask

    task automatic route_test();
        start_test("read_routing");
        for (int k = 0; k < NUM_PORTS; k++) begin
            @(negedge sys_clk);
            drive_beat(ID_WIDTH'(k), 1'b1);
            @(posedge sys_clk);
            check_route();
        end
        finish_test();
        start_test("rid_out_of_range");
        @(negedge sys_clk);
        drive_beat(ID_WIDTH'(9), 1'b1);
        s_rready = '1;
        @(posedge sys_clk);
        check_route();
        finish_test();
    endtask

    task automatic random_test();
        logic [NUM_PORTS-1:0] held;
        start_test("random");
        held = '0;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            @(negedge sys_clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                // A pending request waits for its handshake
                if (!held[SEL_W'(p)]) begin
                    s_arvalid[SEL_W'(p)] = 1'($urandom_range(0, 1));
                    s_araddr[SEL_W'(p)]  = $urandom();
                    s_arlen[SEL_W'(p)]   = '0;
                end
            end
            m_arready = 1'($urandom_range(0, 1));
            drive_beat(ID_WIDTH'($urandom_range(0, NUM_PORTS)), 1'($urandom_range(0, 1)));
            @(posedge sys_clk);
            check_route();
            held = s_arvalid & ~s_arready;
        end
        drain_requests();
        finish_test();
    endtask

    initial begin : stimulus
        void'($urandom(32'h21cf9ef5));
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        reset = 1'b1;
        s_araddr = '0;
        s_arlen = '0;
        s_arvalid = '0;
        s_rready = '0;
        m_arready = 1'b0;
        m_rid = '0;
        m_rdata = '0;
        m_rresp = '0;
        m_rlast = 1'b0;
        m_rvalid = 1'b0;
        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);
        reset = 1'b0;
        start_test("reset");
        @(posedge sys_clk);
        check_value("m_arvalid", 64'(0), 64'(m_arvalid));
        check_value("s_rvalid", 64'(0), 64'(s_rvalid));
        check_value("s_rlast", 64'(0), 64'(s_rlast));
        finish_test();
        single_request_test();
        rotation_test();
        back_pressure_test();
        route_test();
        random_test();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", 2 * TEST_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- hdl/axi_rd_arbiter.sv
// AXI4 read arbiter, four ports into one
// Round-robin merge of the upstream AR channels onto one downstream
// port, and ID-based routing of the R channel back.
// Single-beat bursts, one data width on all ports.

`timescale 1ns/1ps

module axi_rd_arbiter #(
    parameter int NUM_PORTS  = 4,
    parameter int ID_WIDTH   = 4,
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 512
) (
    input  logic                                                  sys_clk,
    input  logic                                                  reset,
    // Upstream read address
    input  logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0]                  s_araddr,
    input  logic [NUM_PORTS-1:0][axi_arb_pkg::AXI_LEN_WIDTH-1:0]  s_arlen,
    input  logic [NUM_PORTS-1:0]                                  s_arvalid,
    output logic [NUM_PORTS-1:0]                                  s_arready,
    // Upstream read data
    output logic [NUM_PORTS-1:0][ID_WIDTH-1:0]                    s_rid,
    output logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]                  s_rdata,
    output logic [NUM_PORTS-1:0][axi_arb_pkg::AXI_RESP_WIDTH-1:0] s_rresp,
    output logic [NUM_PORTS-1:0]                                  s_rlast,
    output logic [NUM_PORTS-1:0]                                  s_rvalid,
    input  logic [NUM_PORTS-1:0]                                  s_rready,
    // Downstream read address
    output logic [ID_WIDTH-1:0]                                   m_arid,
    output logic [ADDR_WIDTH-1:0]                                 m_araddr,
    output logic [axi_arb_pkg::AXI_LEN_WIDTH-1:0]                 m_arlen,
    output logic [axi_arb_pkg::AXI_SIZE_WIDTH-1:0]                m_arsize,
    output logic [axi_arb_pkg::AXI_BURST_WIDTH-1:0]               m_arburst,
    output logic                                                  m_arlock,
    output logic [axi_arb_pkg::AXI_CACHE_WIDTH-1:0]               m_arcache,
    output logic [axi_arb_pkg::AXI_PROT_WIDTH-1:0]                m_arprot,
    output logic                                                  m_arvalid,
    input  logic                                                  m_arready,
    // Downstream read data
    input  logic [ID_WIDTH-1:0]                                   m_rid,
    input  logic [DATA_WIDTH-1:0]                                 m_rdata,
    input  logic [axi_arb_pkg::AXI_RESP_WIDTH-1:0]                m_rresp,
    input  logic                                                  m_rlast,
    input  logic                                                  m_rvalid,
    output logic                                                  m_rready
);

    localparam int SIZE_WIDTH = axi_arb_pkg::AXI_SIZE_WIDTH;

    // Full-width beats, log2 of the bytes per beat
    localparam logic [SIZE_WIDTH-1:0] AR_SIZE = SIZE_WIDTH'($clog2(DATA_WIDTH / 8));

    //------------------------------
    // Address channel
    //------------------------------
    ar_merge #(
        .NUM_PORTS  (NUM_PORTS),
        .ID_WIDTH   (ID_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ar_merge (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .s_araddr  (s_araddr),
        .s_arlen   (s_arlen),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .m_arid    (m_arid),
        .m_araddr  (m_araddr),
        .m_arlen   (m_arlen),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready)
    );

    // Fixed attributes
    assign m_arsize  = AR_SIZE;
    assign m_arburst = axi_arb_pkg::BURST_INCR;
    assign m_arlock  = 1'b0;
    assign m_arcache = '0;
    assign m_arprot  = '0;

    //------------------------------
    // Read data channel
    //------------------------------
    r_route #(
        .NUM_PORTS  (NUM_PORTS),
        .ID_WIDTH   (ID_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_r_route (
        .sys_clk  (sys_clk),
        .m_rid    (m_rid),
        .m_rdata  (m_rdata),
        .m_rresp  (m_rresp),
        .m_rlast  (m_rlast),
        .m_rvalid (m_rvalid),
        .m_rready (m_rready),
        .s_rid    (s_rid),
        .s_rdata  (s_rdata),
        .s_rresp  (s_rresp),
        .s_rlast  (s_rlast),
        .s_rvalid (s_rvalid),
        .s_rready (s_rready)
    );

endmodule

//--- hdl/r_route.sv
// Read data router
// Sends the downstream R beat to the port named by rid and returns
// that port's ready. IDs outside the port range are never accepted.

`timescale 1ns/1ps

module r_route #(
    parameter int NUM_PORTS  = 4,
    parameter int ID_WIDTH   = 4,
    parameter int DATA_WIDTH = 512
) (
    input  logic                                                  sys_clk,
    input  logic [ID_WIDTH-1:0]                                   m_rid,
    input  logic [DATA_WIDTH-1:0]                                 m_rdata,
    input  logic [axi_arb_pkg::AXI_RESP_WIDTH-1:0]                m_rresp,
    input  logic                                                  m_rlast,
    input  logic                                                  m_rvalid,
    output logic                                                  m_rready,
    output logic [NUM_PORTS-1:0][ID_WIDTH-1:0]                    s_rid,
    output logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]                  s_rdata,
    output logic [NUM_PORTS-1:0][axi_arb_pkg::AXI_RESP_WIDTH-1:0] s_rresp,
    output logic [NUM_PORTS-1:0]                                  s_rlast,
    output logic [NUM_PORTS-1:0]                                  s_rvalid,
    input  logic [NUM_PORTS-1:0]                                  s_rready
);

    always_comb begin
        m_rready = 1'b0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            // Payload goes to every port, valid only to the owner
            s_rid[k]    = m_rid;
            s_rdata[k]  = m_rdata;
            s_rresp[k]  = m_rresp;
            s_rlast[k]  = m_rlast;
            s_rvalid[k] = m_rvalid && (32'(m_rid) == k);
            if (32'(m_rid) == k) begin
                m_rready = s_rready[k];
            end
        end
    end

    // At most one port sees a beat
    rvalid_onehot: assert property (
        @(posedge sys_clk)
        $onehot0(s_rvalid)
    );

endmodule

//--- hdl/ar_merge.sv
// Read address merge
// Arbitrates the upstream AR requests, tags the winner with its port
// index as ID and queues it for the downstream AR channel.

`timescale 1ns/1ps

module ar_merge #(
    parameter int NUM_PORTS  = 4,
    parameter int ID_WIDTH   = 4,
    parameter int ADDR_WIDTH = 32
) (
    input  logic                                                 sys_clk,
    input  logic                                                 reset,
    input  logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0]                 s_araddr,
    input  logic [NUM_PORTS-1:0][axi_arb_pkg::AXI_LEN_WIDTH-1:0] s_arlen,
    input  logic [NUM_PORTS-1:0]                                 s_arvalid,
    output logic [NUM_PORTS-1:0]                                 s_arready,
    output logic [ID_WIDTH-1:0]                                  m_arid,
    output logic [ADDR_WIDTH-1:0]                                m_araddr,
    output logic [axi_arb_pkg::AXI_LEN_WIDTH-1:0]                m_arlen,
    output logic                                                 m_arvalid,
    input  logic                                                 m_arready
);

    localparam int LEN_WIDTH   = axi_arb_pkg::AXI_LEN_WIDTH;
    localparam int ENTRY_WIDTH = ID_WIDTH + LEN_WIDTH + ADDR_WIDTH;

    logic [NUM_PORTS-1:0]   req;
    logic [NUM_PORTS-1:0]   grant;
    logic [ID_WIDTH-1:0]    grant_id;
    logic [LEN_WIDTH-1:0]   grant_len;
    logic [ADDR_WIDTH-1:0]  grant_addr;
    logic [ENTRY_WIDTH-1:0] buf_in;
    logic [ENTRY_WIDTH-1:0] buf_out;
    logic                   buf_in_ready;

    // No arbitration while the buffer is full
    assign req = buf_in_ready ? s_arvalid : '0;

    rr_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) u_arbiter (
        .sys_clk (sys_clk),
        .reset   (reset),
        .req     (req),
        .grant   (grant)
    );

    assign s_arready = grant;

    //------------------------------
    // Winner select and tag
    //------------------------------
    always_comb begin
        grant_id   = '0;
        grant_len  = '0;
        grant_addr = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            if (grant[k]) begin
                grant_id   = ID_WIDTH'(k);
                grant_len  = s_arlen[k];
                grant_addr = s_araddr[k];
            end
        end
    end

    assign buf_in = {grant_id, grant_len, grant_addr};

    req_buffer #(
        .WIDTH (ENTRY_WIDTH)
    ) u_buffer (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .in_data   (buf_in),
        .in_valid  (|grant),
        .in_ready  (buf_in_ready),
        .out_data  (buf_out),
        .out_valid (m_arvalid),
        .out_ready (m_arready)
    );

    assign {m_arid, m_arlen, m_araddr} = buf_out;

    // AR request held steady until the slave takes it
    ar_hold_stable: assert property (
        @(posedge sys_clk) disable iff (reset)
        m_arvalid && !m_arready |=> m_arvalid && $stable(buf_out)
    );

endmodule

//--- hdl/req_buffer.sv
// Two-entry request buffer
// Small FIFO between the arbiter and the downstream address channel.
// Output comes straight from the storage registers.

`timescale 1ns/1ps

module req_buffer #(
    parameter int WIDTH = 44
) (
    input  logic             sys_clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int DEPTH = 2;

    logic [WIDTH-1:0] mem [DEPTH];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic             full;
    logic             push;
    logic             pop;

    assign full      = (count == 2'd2);
    assign in_ready  = !full;
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    //------------------------------
    // Storage
    //------------------------------
    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    //------------------------------
    // Pointers and occupancy
    //------------------------------
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // Upstream only offers an entry while a slot is free
    no_push_when_full: assert property (
        @(posedge sys_clk) disable iff (reset)
        in_valid |-> !full
    );

endmodule

//--- hdl/rr_arbiter.sv
// Rotating-priority arbiter
// Grants at most one requester per cycle, one-hot, starting the search
// at the priority pointer. The pointer moves past each winner.

`timescale 1ns/1ps

module rr_arbiter #(
    parameter int NUM_PORTS = 4
) (
    input  logic                 sys_clk,
    input  logic                 reset,
    input  logic [NUM_PORTS-1:0] req,
    output logic [NUM_PORTS-1:0] grant
);

    localparam int PTR_WIDTH = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [PTR_WIDTH-1:0] ptr;
    logic [PTR_WIDTH-1:0] win_idx;
    logic                 found;

    //------------------------------
    // Grant search
    //------------------------------
    always_comb begin : search
        int idx;
        grant   = '0;
        win_idx = ptr;
        found   = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = (int'(ptr) + i) % NUM_PORTS;
            if (!found && req[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                win_idx    = PTR_WIDTH'(idx);
            end
        end
    end

    //------------------------------
    // Priority pointer
    //------------------------------
    // Port after the winner gets top priority next
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (found) begin
            if (win_idx == PTR_WIDTH'(NUM_PORTS - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= win_idx + 1'b1;
            end
        end
    end

    // Grant never shared between ports
    grant_onehot: assert property (
        @(posedge sys_clk) disable iff (reset)
        $onehot0(grant)
    );

    // Nobody is granted without asking
    grant_to_req: assert property (
        @(posedge sys_clk) disable iff (reset)
        (grant & ~req) == '0
    );

endmodule

//--- hdl/axi_arb_pkg.sv
// AXI read arbiter shared definitions
// Field widths of the AXI4 address and read data channels,
// and the burst-type encoding driven downstream

package axi_arb_pkg;

    //------------------------------
    // AXI4 field widths
    //------------------------------
    parameter int AXI_LEN_WIDTH   = 8;
    parameter int AXI_SIZE_WIDTH  = 3;
    parameter int AXI_BURST_WIDTH = 2;
    parameter int AXI_RESP_WIDTH  = 2;
    parameter int AXI_CACHE_WIDTH = 4;
    parameter int AXI_PROT_WIDTH  = 3;

    //------------------------------
    // Burst type
    //------------------------------
    // Only INCR is issued by the arbiter
    typedef enum logic [AXI_BURST_WIDTH-1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

endpackage
